// ==== design/tpu_consts.svh ====
`ifndef TPU_CONSTS_SVH
`define TPU_CONSTS_SVH

// ======================================================================
// Array geometry and datapath widths
// ======================================================================
`define TPU_SA_N          4     // Array side, also lanes per word
`define TPU_DATA_W        8     // One int8 lane
`define TPU_ACC_W         32    // Accumulator width
`define TPU_WORD_W        32    // Host and tensor word

// ======================================================================
// Memory depths and tile sequencing
// ======================================================================
`define TPU_TENSOR_DEPTH  64    // Words per ping-pong buffer
`define TPU_WEIGHT_DEPTH  64    // Weight words
`define TPU_K_MAX         16    // Longest tile in feed steps
`define TPU_DRAIN_CYCLES  8     // Skew plus propagation flush after last feed
`define TPU_TARGET_W      2     // Host target selector

`endif

// ==== design/tpu_pkg.sv ====
`include "tpu_consts.svh"

package tpu_pkg;

    // One int8 operand lane
    typedef logic signed [`TPU_DATA_W-1:0] lane_t;

    // Four lanes packed into one word, lane 0 in the low byte
    typedef lane_t [`TPU_SA_N-1:0] lanes_t;

    // Accumulator and bias value
    typedef logic signed [`TPU_ACC_W-1:0] acc_t;

    // Host word, either four int8 lanes or one int32 bias
    typedef union packed {
        lanes_t lanes;  // Tensor and weight data
        acc_t   acc;    // Bias data
    } host_word_u;

    // Where a host write lands
    typedef enum logic [`TPU_TARGET_W-1:0] {
        BUF_A  = 2'd0,
        BUF_B  = 2'd1,
        WEIGHT = 2'd2,
        BIAS   = 2'd3
    } host_target_e;

endpackage

// ==== design/tpu_if.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

// Host write bus, one write per cycle, no response
interface host_wr_if;

    logic                                   en;      // Write strobe
    tpu_pkg::host_target_e                  target;  // Which store takes the word
    logic [$clog2(`TPU_TENSOR_DEPTH)-1:0]   addr;    // Word address, bias column in 1:0
    tpu_pkg::host_word_u                    data;    // Lanes or int32 view

    modport source (output en, output target, output addr, output data);
    modport sink   (input  en, input  target, input  addr, input  data);

endinterface

// ==== design/tpu_ctrl.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module tpu_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic [4:0] k_len,
    output logic       busy,
    output logic       done,
    output logic       ptr_reset,
    output logic       rd_en,
    output logic       acc_clear,
    output logic       wb_en,
    output logic [1:0] wb_row
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD,   // Bias preload, pointer reset
        ST_FEED,   // One memory read per step
        ST_DRAIN,  // Wavefront finishes crossing the grid
        ST_WRITE   // One accumulator row per cycle
    } state_t;

    state_t     state;
    logic [4:0] cnt;       // Shared step counter
    logic [4:0] k_eff;     // k_len clamped to the longest tile
    logic       last_wb;   // Last row strobe, delayed to match result register

    assign k_eff = (k_len > 5'(`TPU_K_MAX)) ? 5'(`TPU_K_MAX) : k_len;

    // ======================================================================
    // Sequencer
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (start && !busy) state <= ST_LOAD;  // Start while busy dropped
                end
                ST_LOAD: begin
                    cnt   <= '0;
                    state <= (k_eff == '0) ? ST_DRAIN : ST_FEED;
                end
                ST_FEED: begin
                    if (cnt == k_eff - 5'd1) begin
                        cnt   <= '0;
                        state <= ST_DRAIN;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                ST_DRAIN: begin
                    if (cnt == 5'(`TPU_DRAIN_CYCLES - 1)) begin
                        cnt   <= '0;
                        state <= ST_WRITE;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                ST_WRITE: begin
                    if (cnt == 5'(`TPU_SA_N - 1)) begin
                        cnt   <= '0;
                        state <= ST_IDLE;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Busy spans the whole tile up to the last result row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            last_wb <= 1'b0;
        end else begin
            last_wb <= wb_en && (cnt == 5'(`TPU_SA_N - 1));
            done    <= last_wb;                  // Cycle after the last res_valid
            if (last_wb)
                busy <= 1'b0;                    // Falls with done
            else if (start && !busy)
                busy <= 1'b1;
        end
    end

    // Strobes straight from state
    assign ptr_reset = (state == ST_LOAD);
    assign acc_clear = (state == ST_LOAD);
    assign rd_en     = (state == ST_FEED);
    assign wb_en     = (state == ST_WRITE);
    assign wb_row    = cnt[1:0];

endmodule

// ==== design/tensor_buffers.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module tensor_buffers (
    input  logic             clk,
    input  logic             rst_n,
    host_wr_if.sink          host,
    input  logic             src_sel,
    input  logic             ptr_reset,
    input  logic             rd_en,
    input  logic             res_valid,
    input  logic [1:0]       res_row,
    input  tpu_pkg::lanes_t  res_word,
    output tpu_pkg::lanes_t  rd_lanes,
    output logic             rd_valid
);

    localparam int ADDR_W = $clog2(`TPU_TENSOR_DEPTH);

    tpu_pkg::lanes_t   mem_a [`TPU_TENSOR_DEPTH];  // Ping buffer
    tpu_pkg::lanes_t   mem_b [`TPU_TENSOR_DEPTH];  // Pong buffer
    logic [ADDR_W-1:0] rd_ptr;                     // Shared read pointer
    logic              sel_q;                      // Buffer being read this tile

    // ======================================================================
    // Read side, pointer and source latch
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            sel_q    <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;                     // One cycle read latency
            if (ptr_reset) begin
                rd_ptr <= '0;
                sel_q  <= src_sel;                 // Held for the whole tile
            end else if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en)
            rd_lanes <= sel_q ? mem_b[rd_ptr] : mem_a[rd_ptr];
    end

    // ======================================================================
    // Write side, host and result writeback
    // ======================================================================
    always_ff @(posedge clk) begin
        if (host.en && host.target == tpu_pkg::BUF_A)
            mem_a[host.addr] <= host.data.lanes;
        if (host.en && host.target == tpu_pkg::BUF_B)
            mem_b[host.addr] <= host.data.lanes;
        // Results go to the buffer not being read
        if (res_valid && sel_q)
            mem_a[ADDR_W'(res_row)] <= res_word;
        if (res_valid && !sel_q)
            mem_b[ADDR_W'(res_row)] <= res_word;
    end

endmodule

// ==== design/weight_store.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module weight_store (
    input  logic             clk,
    input  logic             rst_n,
    host_wr_if.sink          host,
    input  logic [5:0]       w_base,
    input  logic             ptr_reset,
    input  logic             rd_en,
    output tpu_pkg::lanes_t  rd_lanes,
    output logic             rd_valid,
    output tpu_pkg::acc_t    bias [`TPU_SA_N]
);

    localparam int ADDR_W = $clog2(`TPU_WEIGHT_DEPTH);

    tpu_pkg::lanes_t   mem [`TPU_WEIGHT_DEPTH];    // One word per k step
    logic [ADDR_W-1:0] w_ptr;

    // Pointer starts at the tile's weight base
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            w_ptr    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
            if (ptr_reset)
                w_ptr <= w_base;
            else if (rd_en)
                w_ptr <= w_ptr + 1'b1;
        end
    end

    // ======================================================================
    // Weight RAM and bias registers
    // ======================================================================
    always_ff @(posedge clk) begin
        if (rd_en)
            rd_lanes <= mem[w_ptr];
        if (host.en && host.target == tpu_pkg::WEIGHT)
            mem[host.addr] <= host.data.lanes;
        if (host.en && host.target == tpu_pkg::BIAS)
            bias[host.addr[1:0]] <= host.data.acc;  // int32 view of the word
    end

endmodule

// ==== design/skew_feeder.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module skew_feeder (
    input  logic             clk,
    input  logic             rst_n,
    input  tpu_pkg::lanes_t  in_lanes,
    input  logic             in_valid,
    output tpu_pkg::lanes_t  out_lanes
);

    tpu_pkg::lanes_t masked;

    // Zeros outside the feed window keep the accumulators still
    assign masked = in_valid ? in_lanes : '0;

    for (genvar i = 0; i < `TPU_SA_N; i++) begin : g_lane
        if (i == 0) begin : g_direct
            assign out_lanes[0] = masked[0];       // Lane 0 has no lag
        end else begin : g_delay
            tpu_pkg::lane_t chain [i];             // i stages for lane i

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < i; s++)
                        chain[s] <= '0;
                end else begin
                    chain[0] <= masked[i];
                    for (int s = 1; s < i; s++)
                        chain[s] <= chain[s-1];
                end
            end

            assign out_lanes[i] = chain[i-1];
        end
    end

endmodule

// ==== design/systolic_array.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module systolic_array (
    input  logic             clk,
    input  logic             rst_n,
    input  tpu_pkg::lanes_t  a_lanes,                  // Row i enters on lane i
    input  tpu_pkg::lanes_t  w_lanes,                  // Column j enters on lane j
    input  logic             acc_clear,
    input  tpu_pkg::acc_t    bias [`TPU_SA_N],
    input  logic [1:0]       wb_row,
    output tpu_pkg::acc_t    row_acc [`TPU_SA_N]
);

    localparam int N = `TPU_SA_N;

    tpu_pkg::lane_t a_reg [N][N];                      // a forwarded to the right
    tpu_pkg::lane_t w_reg [N][N];                      // w forwarded downward
    tpu_pkg::acc_t  acc   [N][N];                      // Output-stationary sums

    // ======================================================================
    // MAC grid
    // ======================================================================
    for (genvar i = 0; i < N; i++) begin : g_row
        for (genvar j = 0; j < N; j++) begin : g_col
            tpu_pkg::lane_t a_in;
            tpu_pkg::lane_t w_in;
            tpu_pkg::acc_t  prod;

            if (j == 0) begin : g_a_edge
                assign a_in = a_lanes[i];
            end else begin : g_a_inner
                assign a_in = a_reg[i][j-1];
            end

            if (i == 0) begin : g_w_edge
                assign w_in = w_lanes[j];
            end else begin : g_w_inner
                assign w_in = w_reg[i-1][j];
            end

            assign prod = a_in * w_in;                 // Signed, sign-extended to 32

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    a_reg[i][j] <= '0;
                    w_reg[i][j] <= '0;
                    acc[i][j]   <= '0;
                end else if (acc_clear) begin
                    a_reg[i][j] <= '0;
                    w_reg[i][j] <= '0;
                    acc[i][j]   <= bias[j];            // Column bias preload
                end else begin
                    a_reg[i][j] <= a_in;
                    w_reg[i][j] <= w_in;
                    acc[i][j]   <= acc[i][j] + prod;
                end
            end
        end

        // Row readout, lane i of row_acc is column i
        assign row_acc[i] = acc[wb_row][i];
    end

endmodule

// ==== design/result_writeback.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module result_writeback (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wb_en,
    input  logic [1:0]       wb_row,
    input  tpu_pkg::acc_t    row_acc [`TPU_SA_N],
    output logic             res_valid,
    output logic [1:0]       res_row,
    output tpu_pkg::lanes_t  res_word
);

    tpu_pkg::lanes_t packed_row;

    // Clamp each column to int8, lane j is column j
    always_comb begin
        for (int j = 0; j < `TPU_SA_N; j++) begin
            if (row_acc[j] > 32'sd127)
                packed_row[j] = 8'sd127;
            else if (row_acc[j] < -32'sd128)
                packed_row[j] = -8'sd128;
            else
                packed_row[j] = row_acc[j][`TPU_DATA_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            res_valid <= 1'b0;
        else
            res_valid <= wb_en;
    end

    // Row index and word travel with res_valid
    always_ff @(posedge clk) begin
        if (wb_en) begin
            res_row  <= wb_row;
            res_word <= packed_row;
        end
    end

endmodule

// ==== design/tpu_top.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module tpu_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        host_wr_en,
    input  logic [`TPU_TARGET_W-1:0]    host_target,
    input  logic [5:0]                  host_addr,
    input  logic [`TPU_WORD_W-1:0]      host_wdata,
    input  logic                        start,
    input  logic                        src_sel,
    input  logic [4:0]                  k_len,
    input  logic [5:0]                  w_base,
    output logic                        busy,
    output logic                        done,
    output logic                        res_valid,
    output logic [1:0]                  res_row,
    output logic [`TPU_WORD_W-1:0]      res_word
);

    // ======================================================================
    // Host bus from the plain ports
    // ======================================================================
    host_wr_if host_bus ();

    assign host_bus.en     = host_wr_en;
    assign host_bus.target = tpu_pkg::host_target_e'(host_target);
    assign host_bus.addr   = host_addr;
    assign host_bus.data   = host_wdata;

    logic            ptr_reset, rd_en, acc_clear, wb_en;
    logic [1:0]      wb_row;
    tpu_pkg::lanes_t act_lanes, wgt_lanes;           // Memory read data
    logic            act_valid, wgt_valid;
    tpu_pkg::lanes_t a_skew, w_skew;                 // Diagonal wavefronts
    tpu_pkg::acc_t   bias    [`TPU_SA_N];
    tpu_pkg::acc_t   row_acc [`TPU_SA_N];

    tpu_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .start(start), .k_len(k_len),
        .busy(busy), .done(done), .ptr_reset(ptr_reset), .rd_en(rd_en),
        .acc_clear(acc_clear), .wb_en(wb_en), .wb_row(wb_row)
    );

    tensor_buffers u_bufs (
        .clk(clk), .rst_n(rst_n), .host(host_bus), .src_sel(src_sel),
        .ptr_reset(ptr_reset), .rd_en(rd_en), .res_valid(res_valid),
        .res_row(res_row), .res_word(res_word),
        .rd_lanes(act_lanes), .rd_valid(act_valid)
    );

    weight_store u_wgts (
        .clk(clk), .rst_n(rst_n), .host(host_bus), .w_base(w_base),
        .ptr_reset(ptr_reset), .rd_en(rd_en),
        .rd_lanes(wgt_lanes), .rd_valid(wgt_valid), .bias(bias)
    );

    skew_feeder act_feeder (
        .clk(clk), .rst_n(rst_n), .in_lanes(act_lanes), .in_valid(act_valid),
        .out_lanes(a_skew)
    );

    skew_feeder wgt_feeder (
        .clk(clk), .rst_n(rst_n), .in_lanes(wgt_lanes), .in_valid(wgt_valid),
        .out_lanes(w_skew)
    );

    systolic_array u_array (
        .clk(clk), .rst_n(rst_n), .a_lanes(a_skew), .w_lanes(w_skew),
        .acc_clear(acc_clear), .bias(bias), .wb_row(wb_row), .row_acc(row_acc)
    );

    result_writeback u_wb (
        .clk(clk), .rst_n(rst_n), .wb_en(wb_en), .wb_row(wb_row),
        .row_acc(row_acc), .res_valid(res_valid), .res_row(res_row),
        .res_word(res_word)
    );

endmodule

// ==== test/tb_tpu.sv ====
`timescale 1ns/1ps
`include "tpu_consts.svh"

module tb_tpu;

    localparam int TIMEOUT_CYCLES = 3000;  // Whole run needs a few hundred cycles

    logic        clk;
    logic        rst_n;
    logic        host_wr_en;
    logic [1:0]  host_target;
    logic [5:0]  host_addr;
    logic [31:0] host_wdata;
    logic        start;
    logic        src_sel;
    logic [4:0]  k_len;
    logic [5:0]  w_base;
    logic        busy;
    logic        done;
    logic        res_valid;
    logic [1:0]  res_row;
    logic [31:0] res_word;

    // Reference model state
    logic [31:0] ref_buf [2][`TPU_TENSOR_DEPTH];   // Buffer A and buffer B
    logic [31:0] ref_wgt [`TPU_WEIGHT_DEPTH];
    int          ref_bias [`TPU_SA_N];
    logic [31:0] expected_rows [`TPU_SA_N];
    logic [31:0] got_rows [`TPU_SA_N];             // Last tile as seen on the port
    logic [31:0] rng_state = 32'h6b12_1a5c;
    int          cycles = 0;

    tpu_top dut (
        .clk(clk), .rst_n(rst_n), .host_wr_en(host_wr_en), .host_target(host_target),
        .host_addr(host_addr), .host_wdata(host_wdata), .start(start),
        .src_sel(src_sel), .k_len(k_len), .w_base(w_base), .busy(busy),
        .done(done), .res_valid(res_valid), .res_row(res_row), .res_word(res_word)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                     // 8 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycles);
            $display("Something failed");
            $fatal(1);
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Four lanes in -8..7
    function automatic logic [31:0] small_word(input logic [31:0] r);
        logic [31:0] w;
        for (int j = 0; j < `TPU_SA_N; j++)
            w[8*j +: 8] = {{4{r[4*j+3]}}, r[4*j +: 4]};
        return w;
    endfunction

    function automatic logic [7:0] clamp_int8(input int v);
        if (v > 127)
            return 8'h7f;
        else if (v < -128)
            return 8'h80;
        else
            return v[7:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // One host write, mirrored into the model
    task automatic host_write(input logic [1:0] target, input logic [5:0] addr,
                              input logic [31:0] data);
        host_wr_en  = 1'b1;
        host_target = target;
        host_addr   = addr;
        host_wdata  = data;
        case (target)
            tpu_pkg::BUF_A:  ref_buf[0][addr] = data;
            tpu_pkg::BUF_B:  ref_buf[1][addr] = data;
            tpu_pkg::WEIGHT: ref_wgt[addr] = data;
            default:         ref_bias[addr[1:0]] = data;  // int32 view
        endcase
        @(negedge clk);
        host_wr_en = 1'b0;
    endtask

    // C[i][j] = bias[j] + sum a_k[i]*w_k[j], clamped, stored in the other buffer
    task automatic model_tile(input int src, input int k_steps, input int wbase);
        int          sum;
        logic [31:0] word;
        for (int i = 0; i < `TPU_SA_N; i++) begin
            word = '0;
            for (int j = 0; j < `TPU_SA_N; j++) begin
                sum = ref_bias[j];
                for (int k = 0; k < k_steps; k++)
                    sum = sum + $signed(ref_buf[src][k][8*i +: 8])
                              * $signed(ref_wgt[wbase+k][8*j +: 8]);
                word[8*j +: 8] = clamp_int8(sum);
            end
            expected_rows[i] = word;
        end
        for (int i = 0; i < `TPU_SA_N; i++)
            ref_buf[1-src][i] = expected_rows[i];
    endtask

    // Start a tile and collect rows until done, retry_last repeats start on the last row
    task automatic run_tile(input string name, input int src, input int k_steps,
                            input int wbase, input bit retry_last);
        int rows_seen;
        model_tile(src, k_steps, wbase);
        src_sel = src[0];
        k_len   = k_steps[4:0];
        w_base  = wbase[5:0];
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value(name, 1, busy);                // Busy on the next edge
        rows_seen = 0;
        while (done !== 1'b1) begin
            if (res_valid === 1'b1) begin
                if (rows_seen < `TPU_SA_N) begin
                    check_value(name, rows_seen, res_row);  // Rows in order
                    check_value(name, expected_rows[rows_seen], res_word);
                    got_rows[rows_seen] = res_word;
                end
                rows_seen++;
            end
            // Sequencer is back in idle here while busy is still high
            start = retry_last && (rows_seen == `TPU_SA_N);
            @(negedge clk);
        end
        start = 1'b0;
        check_value(name, `TPU_SA_N, rows_seen);
        check_value(name, 0, busy);                // Falls together with done
        @(negedge clk);
        check_value(name, 0, done);                // One-cycle pulse
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset();
        check_value("reset", 0, busy);
        check_value("reset", 0, done);
        check_value("reset", 0, res_valid);
        repeat (10) begin
            @(negedge clk);
            check_value("reset", 0, res_valid);    // Nothing without a start
            check_value("reset", 0, done);
        end
    endtask

    task automatic test_basic();
        for (int k = 0; k < 4; k++)
            host_write(tpu_pkg::BUF_A, k, small_word(next_random()));
        for (int k = 0; k < 4; k++)
            host_write(tpu_pkg::WEIGHT, k, small_word(next_random()));
        for (int j = 0; j < `TPU_SA_N; j++)
            host_write(tpu_pkg::BIAS, j, int'(next_random() % 128) - 64);
        run_tile("basic", 0, 4, 0, 1'b0);
    endtask

    // Reads the rows the basic tile left in buffer B
    task automatic test_chain();
        for (int k = 0; k < 4; k++)
            host_write(tpu_pkg::WEIGHT, 16 + k, small_word(next_random()));
        run_tile("chain", 1, 4, 16, 1'b0);
    endtask

    task automatic test_saturate();
        for (int k = 0; k < 4; k++)
            host_write(tpu_pkg::BUF_A, k, next_random());   // Full int8 range
        for (int k = 0; k < 4; k++)
            host_write(tpu_pkg::WEIGHT, 24 + k, next_random());
        host_write(tpu_pkg::BIAS, 0, 100000);      // Beyond any 4-step sum
        host_write(tpu_pkg::BIAS, 1, -100000);
        host_write(tpu_pkg::BIAS, 2, int'(next_random() % 256) - 128);
        host_write(tpu_pkg::BIAS, 3, int'(next_random() % 256) - 128);
        run_tile("saturate", 0, 4, 24, 1'b0);
        for (int i = 0; i < `TPU_SA_N; i++) begin
            check_value("saturate", 32'h7f, got_rows[i][7:0]);   // Column 0 clamps high
            check_value("saturate", 32'h80, got_rows[i][15:8]);  // Column 1 clamps low
        end
    endtask

    task automatic test_long_tile();
        for (int k = 0; k < `TPU_K_MAX; k++)
            host_write(tpu_pkg::BUF_A, k, small_word(next_random()));
        for (int k = 0; k < `TPU_K_MAX; k++)
            host_write(tpu_pkg::WEIGHT, 40 + k, next_random());
        run_tile("long_tile", 0, `TPU_K_MAX, 40, 1'b1);
        // A start that was taken would show up as a second tile here
        repeat (40) begin
            @(negedge clk);
            check_value("long_tile", 0, busy);
            check_value("long_tile", 0, res_valid);
            check_value("long_tile", 0, done);
        end
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        rst_n       = 1'b0;
        host_wr_en  = 1'b0;
        host_target = '0;
        host_addr   = '0;
        host_wdata  = '0;
        start       = 1'b0;
        src_sel     = 1'b0;
        k_len       = '0;
        w_base      = '0;
        repeat (2) @(negedge clk);                 // Two rising edges in reset
        rst_n = 1'b1;

        test_reset();
        test_basic();
        test_chain();
        test_saturate();
        test_long_tile();

        $display("Everything OK");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/tpu_pkg.sv
design/tpu_if.sv
design/tpu_ctrl.sv
design/tensor_buffers.sv
design/weight_store.sv
design/skew_feeder.sv
design/systolic_array.sv
design/result_writeback.sv
design/tpu_top.sv
test/tb_tpu.sv
